// ==== src/board_config.svh ====
// ----------------------------------------
// Board configuration
// Widths, counts, polarity and the bit
// positions of the settings word
// ----------------------------------------
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

`define BOARD_COLORW          4
`define BOARD_BUTTONS         2
`define BOARD_ACTIVE_LOW      1
`define BOARD_RST_CYCLES      16
`define BOARD_GAME_RST_CYCLES 32
`define BOARD_BLINK_FRAMES    4
`define BOARD_VIDEO_WIDTH     384
`define BOARD_VIDEO_HEIGHT    224

// Settings word bits
`define BOARD_ST_ROT   1
`define BOARD_ST_FLIP  2
`define BOARD_ST_PAUSE 3
`define BOARD_ST_BW    4
`define BOARD_ST_NOFM  5
`define BOARD_ST_NOPSG 6
`define BOARD_ST_TEST  7
// Low bits of the 2-bit fields
`define BOARD_ST_FX    8
`define BOARD_ST_AR    10

`endif

// ==== src/board_ctrl_pkg.sv ====
// ----------------------------------------
// Control types
// Joystick words and settings values
// ----------------------------------------
package board_ctrl_pkg;

    // Board joystick, active high
    typedef struct packed {
        logic [1:0] unused;
        logic       service;
        logic       pause;
        logic       coin;
        logic       start;
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } board_joy_t;

    // Game joystick, same order as the low ten board bits
    typedef struct packed {
        logic [5:0] buttons;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } game_joy_t;

    typedef logic [11:0] aspect_t;

endpackage

// ==== src/board_video_pkg.sv ====
// ----------------------------------------
// Video types
// Game and output colour channels
// ----------------------------------------
`include "board_config.svh"

package board_video_pkg;

    // Native game channel
    typedef logic [`BOARD_COLORW-1:0] game_colour_t;

    // Extended channel for the video output
    typedef logic [7:0] out_colour_t;

endpackage

// ==== src/board_settings_if.sv ====
// ----------------------------------------
// Decoded settings
// Level signals from the DIP decoder to
// the reset, input and video blocks
// ----------------------------------------
`timescale 1ns/1ps

interface board_settings_if;

    // All in the clk_sys domain
    logic rot_control;
    logic flip;
    logic osd_pause;
    logic bw_en;

    modport dip    (output rot_control, output flip, output osd_pause, output bw_en);
    modport inputs (input rot_control, input osd_pause);
    modport reset  (input flip);
    modport video  (input bw_en);

endinterface

// ==== src/board_reset.sv ====
// ----------------------------------------
// Reset sequencer
// System reset and game reset, each held
// a fixed time after its last cause
// ----------------------------------------
`timescale 1ns/1ps
`include "board_config.svh"

module board_reset (
    input  logic             clk_sys,
    input  logic             reset,
    input  logic             pll_locked,
    input  logic             rst_req,
    input  logic             downloading,
    input  logic             soft_rst,
    board_settings_if.reset  settings,
    output logic             rst,
    output logic             game_rst
);

    localparam int RST_W  = $clog2(`BOARD_RST_CYCLES + 1);
    localparam int GAME_W = $clog2(`BOARD_GAME_RST_CYCLES + 1);

    logic [RST_W-1:0]  rst_cnt;
    logic [GAME_W-1:0] game_cnt;
    logic              flip_last;
    logic              sys_cause;
    logic              game_cause;

    assign sys_cause  = reset | rst_req | ~pll_locked;
    assign rst        = sys_cause | (rst_cnt != '0);

    // Flip change forces a game restart
    assign game_cause = rst | downloading | soft_rst | (settings.flip != flip_last);
    assign game_rst   = game_cause | (game_cnt != '0);

    always_ff @(posedge clk_sys) begin
        if (sys_cause) begin
            rst_cnt <= RST_W'(`BOARD_RST_CYCLES);
        end else if (rst_cnt != '0) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (game_cause) begin
            game_cnt <= GAME_W'(`BOARD_GAME_RST_CYCLES);
        end else if (game_cnt != '0) begin
            game_cnt <= game_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            flip_last <= 1'b0;
        end else begin
            flip_last <= settings.flip;
        end
    end

endmodule

// ==== src/board_dip.sv ====
// ----------------------------------------
// Settings decoder
// Registers the fields of the settings word
// ----------------------------------------
`timescale 1ns/1ps
`include "board_config.svh"

module board_dip (
    input  logic                   clk_sys,
    input  logic                   rst,
    input  logic [31:0]            status,
    board_settings_if.dip          settings,
    output board_ctrl_pkg::aspect_t hdmi_arx,
    output board_ctrl_pkg::aspect_t hdmi_ary,
    output logic                   enable_fm,
    output logic                   enable_psg,
    output logic                   dip_test,
    output logic                   dip_flip,
    output logic [1:0]             dip_fxlevel
);

    // Screen flip goes to the game and to the reset block
    assign dip_flip = settings.flip;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            enable_fm            <= 1'b1;
            enable_psg           <= 1'b1;
            dip_test             <= 1'b0;
            dip_fxlevel          <= 2'd0;
            settings.flip        <= 1'b0;
            settings.rot_control <= 1'b0;
            settings.osd_pause   <= 1'b0;
            settings.bw_en       <= 1'b0;
            hdmi_arx             <= 12'd4;
            hdmi_ary             <= 12'd3;
        end else begin
            // Disable bits in the word
            enable_fm            <= ~status[`BOARD_ST_NOFM];
            enable_psg           <= ~status[`BOARD_ST_NOPSG];
            dip_test             <= status[`BOARD_ST_TEST];
            dip_fxlevel          <= status[`BOARD_ST_FX +: 2];
            settings.flip        <= status[`BOARD_ST_FLIP];
            settings.rot_control <= status[`BOARD_ST_ROT];
            settings.osd_pause   <= status[`BOARD_ST_PAUSE];
            settings.bw_en       <= status[`BOARD_ST_BW];
            case (status[`BOARD_ST_AR +: 2])
                2'd0: begin
                    hdmi_arx <= 12'd4;
                    hdmi_ary <= 12'd3;
                end
                2'd1: begin
                    hdmi_arx <= 12'd16;
                    hdmi_ary <= 12'd9;
                end
                default: begin
                    // Native pixel size
                    hdmi_arx <= 12'(`BOARD_VIDEO_WIDTH);
                    hdmi_ary <= 12'(`BOARD_VIDEO_HEIGHT);
                end
            endcase
        end
    end

endmodule

// ==== src/board_inputs.sv ====
// ----------------------------------------
// Joystick mapping
// Masking, rotation, polarity, pause
// toggle and soft reset combination
// ----------------------------------------
`timescale 1ns/1ps
`include "board_config.svh"

module board_inputs (
    input  logic                      clk_sys,
    input  logic                      rst,
    board_settings_if.inputs          settings,
    input  board_ctrl_pkg::board_joy_t board_joystick1,
    input  board_ctrl_pkg::board_joy_t board_joystick2,
    output board_ctrl_pkg::game_joy_t  game_joystick1,
    output board_ctrl_pkg::game_joy_t  game_joystick2,
    output logic [1:0]                game_coin,
    output logic [1:0]                game_start,
    output logic                      game_service,
    output logic                      dip_pause,
    output logic                      soft_rst
);

    localparam logic [5:0] BTN_MASK = 6'((1 << `BOARD_BUTTONS) - 1);
    localparam logic       INV      = 1'(`BOARD_ACTIVE_LOW);

    logic [1:0] pause_last;
    logic       pause_tog;
    logic       combo;
    logic       combo_last;

    // Active high game word with unused buttons cleared
    function automatic board_ctrl_pkg::game_joy_t map_joy(
        input board_ctrl_pkg::board_joy_t b,
        input logic                       rot
    );
        board_ctrl_pkg::game_joy_t g;
        g.buttons = b.buttons & BTN_MASK;
        if (rot) begin
            g.right = b.up;
            g.left  = b.down;
            g.down  = b.right;
            g.up    = b.left;
        end else begin
            g.right = b.right;
            g.left  = b.left;
            g.down  = b.down;
            g.up    = b.up;
        end
        return g;
    endfunction

    assign combo     = board_joystick1.start & board_joystick1.coin;
    assign dip_pause = ~(pause_tog | settings.osd_pause);

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= {10{INV}};
            game_joystick2 <= {10{INV}};
            game_coin      <= {2{INV}};
            game_start     <= {2{INV}};
            game_service   <= INV;
            pause_last     <= 2'b00;
            pause_tog      <= 1'b0;
            combo_last     <= 1'b0;
            soft_rst       <= 1'b0;
        end else begin
            game_joystick1 <= map_joy(board_joystick1, settings.rot_control) ^ {10{INV}};
            game_joystick2 <= map_joy(board_joystick2, settings.rot_control) ^ {10{INV}};
            game_coin      <= {board_joystick2.coin, board_joystick1.coin} ^ {2{INV}};
            game_start     <= {board_joystick2.start, board_joystick1.start} ^ {2{INV}};
            game_service   <= (board_joystick1.service | board_joystick2.service) ^ INV;
            pause_last     <= {board_joystick2.pause, board_joystick1.pause};
            // Either player can toggle
            if (|({board_joystick2.pause, board_joystick1.pause} & ~pause_last)) begin
                pause_tog <= ~pause_tog;
            end
            combo_last     <= combo;
            soft_rst       <= combo & ~combo_last;
        end
    end

endmodule

// ==== src/board_led.sv ====
// ----------------------------------------
// Status LED
// Blinks by frames while downloading
// ----------------------------------------
`timescale 1ns/1ps
`include "board_config.svh"

module board_led (
    input  logic       clk_sys,
    input  logic       rst,
    input  logic       lvbl,
    input  logic       downloading,
    input  logic       osd_shown,
    input  logic [1:0] game_led,
    output logic       led
);

    localparam int CNT_W = $clog2(`BOARD_BLINK_FRAMES);

    logic [CNT_W-1:0] frame_cnt;
    logic [CNT_W-1:0] cnt_next;
    logic             blink;
    logic             blink_next;
    logic             lvbl_last;
    logic             dl_last;

    always_comb begin
        cnt_next   = frame_cnt;
        blink_next = blink;
        if (downloading & ~dl_last) begin
            cnt_next   = '0;
            blink_next = 1'b0;
        end else if (downloading & lvbl_last & ~lvbl) begin
            // End of frame
            if (frame_cnt == CNT_W'(`BOARD_BLINK_FRAMES - 1)) begin
                cnt_next   = '0;
                blink_next = ~blink;
            end else begin
                cnt_next = frame_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            frame_cnt <= '0;
            blink     <= 1'b0;
            lvbl_last <= 1'b0;
            dl_last   <= 1'b0;
            led       <= 1'b0;
        end else begin
            frame_cnt <= cnt_next;
            blink     <= blink_next;
            lvbl_last <= lvbl;
            dl_last   <= downloading;
            led       <= downloading ? blink_next : (game_led[0] | osd_shown);
        end
    end

endmodule

// ==== src/board_video.sv ====
// ----------------------------------------
// Video output stage
// Optional bandwidth filter and 8-bit
// colour extension
// ----------------------------------------
`timescale 1ns/1ps
`include "board_config.svh"

module board_video (
    input  logic                        clk_sys,
    input  logic                        rst,
    board_settings_if.video             settings,
    input  logic                        pxl_cen,
    input  board_video_pkg::game_colour_t game_r,
    input  board_video_pkg::game_colour_t game_g,
    input  board_video_pkg::game_colour_t game_b,
    input  logic                        hs,
    input  logic                        vs,
    input  logic                        lhbl,
    input  logic                        lvbl,
    output board_video_pkg::out_colour_t  video_r,
    output board_video_pkg::out_colour_t  video_g,
    output board_video_pkg::out_colour_t  video_b,
    output logic                        video_hs,
    output logic                        video_vs,
    output logic                        video_de
);

    localparam int CW = `BOARD_COLORW;

    board_video_pkg::game_colour_t prev_r;
    board_video_pkg::game_colour_t prev_g;
    board_video_pkg::game_colour_t prev_b;

    // Average of two samples, or the current one when off
    function automatic board_video_pkg::out_colour_t shade(
        input board_video_pkg::game_colour_t cur,
        input board_video_pkg::game_colour_t prev,
        input logic                          en
    );
        logic [CW:0]                   sum;
        board_video_pkg::game_colour_t c;
        board_video_pkg::out_colour_t  o;
        sum = {1'b0, cur} + {1'b0, prev};
        c   = en ? sum[CW:1] : cur;
        // Repeat bits from the top down to fill 8 bits
        for (int i = 0; i < 8; i++) begin
            o[7-i] = c[CW-1-(i % CW)];
        end
        return o;
    endfunction

    always_ff @(posedge clk_sys) begin
        if (pxl_cen) begin
            prev_r <= game_r;
            prev_g <= game_g;
            prev_b <= game_b;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            video_r  <= 8'd0;
            video_g  <= 8'd0;
            video_b  <= 8'd0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end else if (pxl_cen) begin
            video_r  <= shade(game_r, prev_r, settings.bw_en);
            video_g  <= shade(game_g, prev_g, settings.bw_en);
            video_b  <= shade(game_b, prev_b, settings.bw_en);
            video_hs <= hs;
            video_vs <= vs;
            video_de <= lhbl & lvbl;
        end
    end

endmodule

// ==== src/arcade_board.sv ====
// ----------------------------------------
// Arcade board wrapper
// Reset, settings, joysticks, LED and
// video stage of the core
// ----------------------------------------
`timescale 1ns/1ps

module arcade_board (
    input  logic                          clk_sys,
    input  logic                          reset,
    input  logic                          pll_locked,
    input  logic                          rst_req,
    input  logic                          downloading,
    input  logic                          osd_shown,
    input  logic [1:0]                    game_led,
    input  logic [31:0]                   status,
    input  board_ctrl_pkg::board_joy_t    board_joystick1,
    input  board_ctrl_pkg::board_joy_t    board_joystick2,
    input  board_video_pkg::game_colour_t game_r,
    input  board_video_pkg::game_colour_t game_g,
    input  board_video_pkg::game_colour_t game_b,
    input  logic                          hs,
    input  logic                          vs,
    input  logic                          lhbl,
    input  logic                          lvbl,
    input  logic                          pxl_cen,
    output logic                          rst,
    output logic                          game_rst,
    output board_ctrl_pkg::aspect_t       hdmi_arx,
    output board_ctrl_pkg::aspect_t       hdmi_ary,
    output logic                          enable_fm,
    output logic                          enable_psg,
    output logic                          dip_test,
    output logic                          dip_flip,
    output logic [1:0]                    dip_fxlevel,
    output board_ctrl_pkg::game_joy_t     game_joystick1,
    output board_ctrl_pkg::game_joy_t     game_joystick2,
    output logic [1:0]                    game_coin,
    output logic [1:0]                    game_start,
    output logic                          game_service,
    output logic                          dip_pause,
    output logic                          led,
    output board_video_pkg::out_colour_t  video_r,
    output board_video_pkg::out_colour_t  video_g,
    output board_video_pkg::out_colour_t  video_b,
    output logic                          video_hs,
    output logic                          video_vs,
    output logic                          video_de
);

    logic soft_rst;

    board_settings_if u_settings ();

    board_reset u_reset (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .pll_locked  (pll_locked),
        .rst_req     (rst_req),
        .downloading (downloading),
        .soft_rst    (soft_rst),
        .settings    (u_settings.reset),
        .rst         (rst),
        .game_rst    (game_rst)
    );

    board_dip u_dip (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .status      (status),
        .settings    (u_settings.dip),
        .hdmi_arx    (hdmi_arx),
        .hdmi_ary    (hdmi_ary),
        .enable_fm   (enable_fm),
        .enable_psg  (enable_psg),
        .dip_test    (dip_test),
        .dip_flip    (dip_flip),
        .dip_fxlevel (dip_fxlevel)
    );

    board_inputs u_inputs (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .settings        (u_settings.inputs),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .game_joystick1  (game_joystick1),
        .game_joystick2  (game_joystick2),
        .game_coin       (game_coin),
        .game_start      (game_start),
        .game_service    (game_service),
        .dip_pause       (dip_pause),
        .soft_rst        (soft_rst)
    );

    board_led u_led (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .lvbl        (lvbl),
        .downloading (downloading),
        .osd_shown   (osd_shown),
        .game_led    (game_led),
        .led         (led)
    );

    board_video u_video (
        .clk_sys  (clk_sys),
        .rst      (rst),
        .settings (u_settings.video),
        .pxl_cen  (pxl_cen),
        .game_r   (game_r),
        .game_g   (game_g),
        .game_b   (game_b),
        .hs       (hs),
        .vs       (vs),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .video_r  (video_r),
        .video_g  (video_g),
        .video_b  (video_b),
        .video_hs (video_hs),
        .video_vs (video_vs),
        .video_de (video_de)
    );

endmodule

// ==== tb/tb_arcade_board.sv ====
// ----------------------------------------
// Testbench for the arcade board wrapper
// Reset holds, file driven joystick and
// settings vectors, LED and video stage
// ----------------------------------------
`timescale 1ns/1ps

module tb_arcade_board;

    logic                          clk_sys = 1'b0;
    logic                          reset;
    logic                          pll_locked;
    logic                          rst_req;
    logic                          downloading;
    logic                          osd_shown;
    logic [1:0]                    game_led;
    logic [31:0]                   status;
    board_ctrl_pkg::board_joy_t    board_joystick1;
    board_ctrl_pkg::board_joy_t    board_joystick2;
    board_video_pkg::game_colour_t game_r;
    board_video_pkg::game_colour_t game_g;
    board_video_pkg::game_colour_t game_b;
    logic                          hs;
    logic                          vs;
    logic                          lhbl;
    logic                          lvbl;
    logic                          pxl_cen;
    logic                          rst;
    logic                          game_rst;
    board_ctrl_pkg::aspect_t       hdmi_arx;
    board_ctrl_pkg::aspect_t       hdmi_ary;
    logic                          enable_fm;
    logic                          enable_psg;
    logic                          dip_test;
    logic                          dip_flip;
    logic [1:0]                    dip_fxlevel;
    board_ctrl_pkg::game_joy_t     game_joystick1;
    board_ctrl_pkg::game_joy_t     game_joystick2;
    logic [1:0]                    game_coin;
    logic [1:0]                    game_start;
    logic                          game_service;
    logic                          dip_pause;
    logic                          led;
    board_video_pkg::out_colour_t  video_r;
    board_video_pkg::out_colour_t  video_g;
    board_video_pkg::out_colour_t  video_b;
    logic                          video_hs;
    logic                          video_vs;
    logic                          video_de;

    int               errors;
    int               mark;
    int               tests;
    int               failed;
    int               seed;
    int               fd;
    int               code;
    int               num;
    int               n;
    logic [63:0]      kind;
    logic [8*200-1:0] rest;
    logic [31:0]      st;
    logic [15:0]      w1;
    logic [15:0]      w2;
    logic [31:0]      e [0:6];
    logic [3:0]       prev [0:2];
    logic [7:0]       exp_c [0:2];
    logic [2:0]       exp_sync;

    arcade_board dut (.*);

    always #4 clk_sys = ~clk_sys;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input int id, input string name);
        tests++;
        if (errors != mark) begin
            failed++;
        end
        $display("test %0d %s: %s", id, name, (errors == mark) ? "ok" : "FAILED");
        mark = errors;
    endtask

    // Selector 0 picks rst and any other value game_rst
    function automatic logic level_of(input int which);
        return (which == 0) ? rst : game_rst;
    endfunction

    task automatic wait_low(input int which, input string name, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk_sys);
            cycles++;
        end while (level_of(which) && cycles < 200);
        assert (!level_of(which)) else begin
            $display("timeout: %s still high after %0d cycles", name, cycles);
            errors++;
        end
    endtask

    // Either cause restarts both holds
    task automatic pulse_sys_cause(input logic use_pll);
        int cycles;
        if (use_pll) begin
            pll_locked = 1'b0;
        end else begin
            rst_req = 1'b1;
        end
        @(negedge clk_sys);
        check_val("rst", rst, 1);
        pll_locked = 1'b1;
        rst_req    = 1'b0;
        wait_low(0, "rst", cycles);
        check_val("rst hold cycles", cycles, 16);
        wait_low(1, "game_rst", cycles);
        check_val("game_rst hold cycles", cycles, 32);
    endtask

    task automatic apply_vector();
        status = st;
        if (kind == "dip") begin
            board_joystick1 = w1;
            board_joystick2 = w2;
            @(negedge clk_sys);
            check_val("hdmi_arx", hdmi_arx, e[0]);
            check_val("hdmi_ary", hdmi_ary, e[1]);
            check_val("enable_fm", enable_fm, e[2]);
            check_val("enable_psg", enable_psg, e[3]);
            check_val("dip_test", dip_test, e[4]);
            check_val("dip_flip", dip_flip, e[5]);
            check_val("dip_fxlevel", dip_fxlevel, e[6]);
            end_test(num, "settings vector");
        end else begin
            // Rotation settles first so the board words show their one cycle latency
            @(negedge clk_sys);
            board_joystick1 = w1;
            board_joystick2 = w2;
            @(negedge clk_sys);
            check_val("game_joystick1", game_joystick1, e[0]);
            check_val("game_joystick2", game_joystick2, e[1]);
            check_val("game_coin", game_coin, e[2]);
            check_val("game_start", game_start, e[3]);
            check_val("game_service", game_service, e[4]);
            end_test(num, "joystick vector");
        end
    endtask

    task automatic run_patterns();
        fd = $fopen("tb/arcade_board_patterns.txt", "r");
        assert (fd != 0) else begin
            $display("cannot open the pattern file");
            errors++;
        end
        if (fd != 0) begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                if (kind == "#") begin
                    code = $fgets(rest, fd);
                end else begin
                    code = $fscanf(fd, "%d %h %h %h %h %h %h %h %h %h %h",
                                   num, st, w1, w2, e[0], e[1], e[2], e[3], e[4], e[5], e[6]);
                    assert (code == 11) else begin
                        $display("pattern line after test %0d is incomplete", num);
                        errors++;
                    end
                    apply_vector();
                end
            end
            $fclose(fd);
        end
    endtask

    function automatic logic [3:0] average(input logic [3:0] a, input logic [3:0] b);
        logic [4:0] sum;
        sum = a + b;
        return sum[4:1];
    endfunction

    // Four bits repeated fill the byte
    function automatic logic [7:0] expand(input logic [3:0] c);
        return {c, c};
    endfunction

    task automatic check_video();
        check_val("video_r", video_r, exp_c[0]);
        check_val("video_g", video_g, exp_c[1]);
        check_val("video_b", video_b, exp_c[2]);
        check_val("video_hs", video_hs, exp_sync[0]);
        check_val("video_vs", video_vs, exp_sync[1]);
        check_val("video_de", video_de, exp_sync[2]);
    endtask

    task automatic send_pixel(input logic bw);
        logic [15:0] v;
        logic [3:0]  cur [0:2];
        v = 16'($random(seed));
        for (int i = 0; i < 3; i++) begin
            cur[i]   = v[4*i +: 4];
            exp_c[i] = bw ? expand(average(cur[i], prev[i])) : expand(cur[i]);
            prev[i]  = cur[i];
        end
        exp_sync = {v[15] & v[14], v[13], v[12]};
        {game_b, game_g, game_r} = v[11:0];
        {lvbl, lhbl, vs, hs}     = v[15:12];
        pxl_cen = 1'b1;
        @(negedge clk_sys);
        check_video();
        // New values without pxl_cen leave the outputs unchanged
        v = 16'($random(seed));
        {game_b, game_g, game_r} = v[11:0];
        {lvbl, lhbl, vs, hs}     = v[15:12];
        pxl_cen = 1'b0;
        @(negedge clk_sys);
        check_video();
    endtask

    initial begin
        seed            = 97;
        errors          = 0;
        mark            = 0;
        tests           = 0;
        failed          = 0;
        reset           = 1'b1;
        pll_locked      = 1'b1;
        rst_req         = 1'b0;
        downloading     = 1'b0;
        osd_shown       = 1'b0;
        game_led        = 2'd0;
        status          = 32'd0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        game_r          = '0;
        game_g          = '0;
        game_b          = '0;
        hs              = 1'b0;
        vs              = 1'b0;
        lhbl            = 1'b1;
        lvbl            = 1'b1;
        pxl_cen         = 1'b0;
        for (int i = 0; i < 3; i++) begin
            prev[i] = 4'd0;
        end
        repeat (10) @(negedge clk_sys);
        reset = 1'b0;
        wait_low(0, "rst", n);
        check_val("rst hold cycles", n, 16);
        wait_low(1, "game_rst", n);
        check_val("game_rst hold cycles", n, 32);
        end_test(1, "reset release");
        pulse_sys_cause(1'b0);
        end_test(2, "rst_req restart");
        pulse_sys_cause(1'b1);
        end_test(3, "pll_locked restart");

        // Download holds the game only
        downloading = 1'b1;
        repeat (4) @(negedge clk_sys);
        check_val("rst", rst, 0);
        check_val("game_rst", game_rst, 1);
        downloading = 1'b0;
        wait_low(1, "game_rst", n);
        check_val("game_rst hold cycles", n, 32);
        end_test(4, "download hold");

        run_patterns();

        // Pause from either player and then from the menu
        status          = 32'd0;
        board_joystick1 = 16'h1000;
        @(negedge clk_sys);
        check_val("dip_pause", dip_pause, 0);
        board_joystick1 = '0;
        @(negedge clk_sys);
        check_val("dip_pause", dip_pause, 0);
        board_joystick2 = 16'h1000;
        @(negedge clk_sys);
        check_val("dip_pause", dip_pause, 1);
        board_joystick2 = '0;
        status          = 32'h8;
        @(negedge clk_sys);
        check_val("dip_pause", dip_pause, 0);
        status = 32'd0;
        @(negedge clk_sys);
        check_val("dip_pause", dip_pause, 1);
        end_test(30, "pause toggle");

        // Start with coin on player 1
        wait_low(1, "game_rst", n);
        board_joystick1 = 16'h0c00;
        @(negedge clk_sys);
        check_val("game_rst", game_rst, 1);
        board_joystick1 = '0;
        @(negedge clk_sys);
        wait_low(1, "game_rst", n);
        check_val("game_rst hold cycles", n, 32);
        end_test(31, "soft reset");

        wait_low(1, "game_rst", n);
        status = 32'h4;
        @(negedge clk_sys);
        check_val("game_rst", game_rst, 1);
        @(negedge clk_sys);
        wait_low(1, "game_rst", n);
        check_val("game_rst hold cycles", n, 32);
        end_test(32, "flip restart");

        for (int i = 0; i < 8; i++) begin
            game_led  = i[1:0];
            osd_shown = i[2];
            @(negedge clk_sys);
            check_val("led", led, i[0] | i[2]);
        end
        end_test(33, "led follow");

        // Phase starts low and flips every fourth frame
        downloading = 1'b1;
        @(negedge clk_sys);
        check_val("led", led, 0);
        for (int f = 1; f <= 8; f++) begin
            lvbl = 1'b0;
            @(negedge clk_sys);
            check_val("led", led, (f / 4) % 2);
            lvbl = 1'b1;
            @(negedge clk_sys);
        end
        downloading = 1'b0;
        end_test(34, "led download blink");

        status = 32'd0;
        repeat (2) @(negedge clk_sys);
        for (int k = 0; k < 8; k++) begin
            send_pixel(1'b0);
        end
        end_test(35, "video filter off");
        status = 32'h10;
        repeat (2) @(negedge clk_sys);
        for (int k = 0; k < 8; k++) begin
            send_pixel(1'b1);
        end
        end_test(36, "video filter on");

        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== arcade_board.f ====
+incdir+src
src/board_ctrl_pkg.sv
src/board_video_pkg.sv
src/board_settings_if.sv
src/board_reset.sv
src/board_dip.sv
src/board_inputs.sv
src/board_led.sv
src/board_video.sv
src/arcade_board.sv
tb/tb_arcade_board.sv

// ==== tb/arcade_board_patterns.txt ====
# kind test status joy1 joy2 e0 e1 e2 e3 e4 e5 e6 (test in decimal, the rest in hex)
# joy: e0..e4 = game1 game2 coin start service   dip: arx ary fm psg test flip fxlevel
joy 10 00000000 0000 0000 3ff 3ff 3 3 1 0 0
joy 11 00000000 0001 0030 3fe 3cf 3 3 1 0 0
joy 12 00000000 03c0 000a 3ff 3f5 3 3 1 0 0
joy 13 00000000 0400 0800 3ff 3ff 1 2 1 0 0
joy 14 00000000 2000 0000 3ff 3ff 3 3 0 0 0
joy 15 00000002 0008 0001 3fe 3fb 3 3 1 0 0
joy 16 00000002 0004 0002 3fd 3f7 3 3 1 0 0
joy 17 00000002 001f 0000 3e0 3ff 3 3 1 0 0
dip 18 00000000 0000 0000 004 003 1 1 0 0 0
dip 19 00000020 0000 0000 004 003 0 1 0 0 0
dip 20 00000040 0000 0000 004 003 1 0 0 0 0
dip 21 00000080 0000 0000 004 003 1 1 1 0 0
dip 22 00000004 0000 0000 004 003 1 1 0 1 0
dip 23 00000100 0000 0000 004 003 1 1 0 0 1
dip 24 00000300 0000 0000 004 003 1 1 0 0 3
dip 25 00000400 0000 0000 010 009 1 1 0 0 0
dip 26 00000800 0000 0000 180 0e0 1 1 0 0 0
dip 27 00000c00 0000 0000 180 0e0 1 1 0 0 0
dip 28 00000ce4 0000 0000 180 0e0 0 0 1 1 0
